/* common/soc_bus_pkg.sv */
// Internal bus widths and the request and response structs
// Bridge state encoding and the byte merge helper for byte-enabled writes

package soc_bus_pkg;

  localparam int unsigned AddrWidth = 64;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_WRITE,
    WAIT_WRITE,
    SEND_READ,
    WAIT_READ
  } sba_state_e;

  // Replace only the bytes whose enable is set
  function automatic logic [DataWidth-1:0] byte_merge(input logic [DataWidth-1:0] old_data,
                                                      input logic [DataWidth-1:0] new_data,
                                                      input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_data[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* common/soc_map_pkg.sv */
// SoC memory map: region bases and lengths, decoded targets
// Control register offsets and the L2 depth

package soc_map_pkg;

  typedef enum logic [1:0] {
    L2MEM,
    CTRL,
    DEBUG,
    NONE
  } target_e;

  // DRAM region, backed by the L2 SRAM
  localparam logic [63:0] DramBase    = 64'h8000_0000;
  localparam logic [63:0] DramLength  = 64'h4000_0000;

  localparam logic [63:0] CtrlBase    = 64'hD000_0000;
  localparam logic [63:0] CtrlLength  = 64'h1000;

  // Debug module window, forwarded off-chip
  localparam logic [63:0] DebugBase   = 64'h0000_0000;
  localparam logic [63:0] DebugLength = 64'h1000;

  localparam int unsigned L2NumWords  = 256;

  localparam logic [63:0] CtrlExitOffset  = 64'h0;
  localparam logic [63:0] CtrlCntEnOffset = 64'h8;

endpackage

/* verilog/l2_sram.sv */
// L2 SRAM: 64-bit words with byte enables, one-cycle response

`timescale 1ns/100ps

module l2_sram (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [DataWidth-1:0]              mem [L2NumWords];
  logic [$clog2(L2NumWords)-1:0]     idx;
  logic [DataWidth-1:0]              rdata_q;
  logic                              valid_q;

  // Word index above the byte offset, upper address bits alias
  assign idx = req_i.addr[$clog2(StrbWidth) +: $clog2(L2NumWords)];

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (req_i.be[b]) begin
            mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o = '{valid: valid_q, rdata: rdata_q};

  a_rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.valid |-> $past(req_i.valid));

endmodule

/* verilog/ctrl_regs.sv */
// Control registers: exit code and hardware counter enable
// Byte-enabled writes, read-back with one-cycle response

`timescale 1ns/100ps

module ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output logic [63:0]           exit_o,
  output logic [63:0]           hw_cnt_en_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [63:0]          offset;
  logic [63:0]          exit_q;
  logic [63:0]          cnt_en_q;
  logic [DataWidth-1:0] rdata_q;
  logic                 valid_q;

  assign offset = req_i.addr - CtrlBase;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      if (req_i.valid && req_i.we) begin
        // Unused offsets are ignored
        if (offset == CtrlExitOffset) exit_q <= byte_merge(exit_q, req_i.wdata, req_i.be);
        if (offset == CtrlCntEnOffset) cnt_en_q <= byte_merge(cnt_en_q, req_i.wdata, req_i.be);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (!req_i.we && offset == CtrlExitOffset) rdata_q <= exit_q;
      else if (!req_i.we && offset == CtrlCntEnOffset) rdata_q <= cnt_en_q;
      else rdata_q <= '0;
    end
  end

  assign rsp_o       = '{valid: valid_q, rdata: rdata_q};
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

/* verilog/soc_bus_decoder.sv */
// Address decoder for the internal bus
// Steers requests to L2, control registers or the debug window,
// and returns the selected target's response one cycle later

`timescale 1ns/100ps

module soc_bus_decoder (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  soc_bus_pkg::bus_req_t             bus_req_i,
  input  soc_bus_pkg::bus_rsp_t             l2_rsp_i,
  input  soc_bus_pkg::bus_rsp_t             ctrl_rsp_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] dm_device_rdata_i,
  output soc_bus_pkg::bus_rsp_t             bus_rsp_o,
  output soc_bus_pkg::bus_req_t             l2_req_o,
  output soc_bus_pkg::bus_req_t             ctrl_req_o,
  output logic                              dm_device_req_o,
  output logic                              dm_device_we_o,
  output logic [soc_bus_pkg::AddrWidth-1:0] dm_device_addr_o,
  output logic [soc_bus_pkg::StrbWidth-1:0] dm_device_be_o,
  output logic [soc_bus_pkg::DataWidth-1:0] dm_device_wdata_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  target_e sel, sel_q;
  logic    valid_q;
  logic    we_q;

  function automatic logic in_region(input logic [AddrWidth-1:0] addr,
                                     input logic [63:0] base,
                                     input logic [63:0] len);
    return (addr >= base) && (addr < base + len);
  endfunction

  always_comb begin
    if (in_region(bus_req_i.addr, DramBase, DramLength)) begin
      sel = L2MEM;
    end else if (in_region(bus_req_i.addr, CtrlBase, CtrlLength)) begin
      sel = CTRL;
    end else if (in_region(bus_req_i.addr, DebugBase, DebugLength)) begin
      sel = DEBUG;
    end else begin
      sel = NONE;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request steering
  ////////////////////////////////////////////////////////////

  always_comb begin
    l2_req_o         = bus_req_i;
    l2_req_o.valid   = bus_req_i.valid && (sel == L2MEM);
    ctrl_req_o       = bus_req_i;
    ctrl_req_o.valid = bus_req_i.valid && (sel == CTRL);
  end

  assign dm_device_req_o   = bus_req_i.valid && (sel == DEBUG);
  assign dm_device_we_o    = bus_req_i.we;
  assign dm_device_addr_o  = bus_req_i.addr;
  assign dm_device_be_o    = bus_req_i.be;
  assign dm_device_wdata_o = bus_req_i.wdata;

  // Selected target follows the request by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      sel_q   <= NONE;
    end else begin
      valid_q <= bus_req_i.valid;
      we_q    <= bus_req_i.we;
      sel_q   <= sel;
    end
  end

  always_comb begin
    unique case (sel_q)
      L2MEM:   bus_rsp_o = l2_rsp_i;
      CTRL:    bus_rsp_o = ctrl_rsp_i;
      // Debug window data arrives one cycle after its request
      DEBUG:   bus_rsp_o = '{valid: valid_q, rdata: we_q ? '0 : dm_device_rdata_i};
      default: bus_rsp_o = '{valid: valid_q, rdata: '0};
    endcase
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({l2_req_o.valid, ctrl_req_o.valid, dm_device_req_o}));

  // Whichever target is hit, its response comes back exactly one cycle later
  a_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.valid |=> bus_rsp_o.valid);

endmodule

/* sba/sba_bridge_fsm.sv */
// SBA bridge: grants and latches one debug access at a time
// and runs it as a single-beat transaction on the internal bus

`timescale 1ns/100ps

module sba_bridge_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              sba_req_i,
  input  logic                              sba_we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0] sba_addr_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0] sba_be_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] sba_wdata_i,
  input  soc_bus_pkg::bus_rsp_t             bus_rsp_i,
  output logic                              sba_gnt_o,
  output logic                              sba_r_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] sba_r_rdata_o,
  output soc_bus_pkg::bus_req_t             bus_req_o
);
  import soc_bus_pkg::*;

  sba_state_e           state_d, state_q;
  logic [AddrWidth-1:0] addr_q;
  logic [StrbWidth-1:0] be_q;
  logic [DataWidth-1:0] wdata_q;

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    sba_gnt_o     = 1'b0;
    sba_r_valid_o = 1'b0;
    sba_r_rdata_o = '0;
    bus_req_o     = '{valid: 1'b0, we: 1'b0, addr: addr_q, be: be_q, wdata: wdata_q};

    unique case (state_q)
      IDLE: begin
        // Grant in the same cycle, the bus access follows next cycle
        if (sba_req_i) begin
          sba_gnt_o = 1'b1;
          state_d   = sba_we_i ? SEND_WRITE : SEND_READ;
        end
      end
      SEND_WRITE: begin
        bus_req_o.valid = 1'b1;
        bus_req_o.we    = 1'b1;
        state_d         = WAIT_WRITE;
      end
      SEND_READ: begin
        bus_req_o.valid = 1'b1;
        state_d         = WAIT_READ;
      end
      WAIT_WRITE: begin
        // Write completion carries no data
        if (bus_rsp_i.valid) begin
          sba_r_valid_o = 1'b1;
          state_d       = IDLE;
        end
      end
      WAIT_READ: begin
        if (bus_rsp_i.valid) begin
          sba_r_valid_o = 1'b1;
          sba_r_rdata_o = bus_rsp_i.rdata;
          state_d       = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State and request latch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Direction is kept in the state, the rest of the request here
  always_ff @(posedge clk_i) begin
    if (sba_gnt_o) begin
      addr_q  <= sba_addr_i;
      be_q    <= sba_be_i;
      wdata_q <= sba_wdata_i;
    end
  end

  // Grant only from IDLE on a pending request, and the bus request follows next cycle
  a_gnt_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sba_gnt_o |-> ((state_q == IDLE) && sba_req_i) ##1 bus_req_o.valid);

  // Waiting for a response never puts a second request on the bus
  a_no_req_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q inside {WAIT_WRITE, WAIT_READ}) |-> !bus_req_o.valid);

endmodule

/* verilog/sba_soc_top.sv */
// Debug-side SoC top: SBA bridge, bus decoder, L2 SRAM and control registers
// The debug memory window leaves through the dm_device ports

`timescale 1ns/100ps

module sba_soc_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // SBA host port from the debug module
  input  logic                                sba_req_i,
  input  logic                                sba_we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0]   sba_addr_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0]   sba_be_i,
  input  logic [soc_bus_pkg::DataWidth-1:0]   sba_wdata_i,
  output logic                                sba_gnt_o,
  output logic                                sba_r_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0]   sba_r_rdata_o,
  // Debug module memory window
  output logic                                dm_device_req_o,
  output logic                                dm_device_we_o,
  output logic [soc_bus_pkg::AddrWidth-1:0]   dm_device_addr_o,
  output logic [soc_bus_pkg::StrbWidth-1:0]   dm_device_be_o,
  output logic [soc_bus_pkg::DataWidth-1:0]   dm_device_wdata_o,
  input  logic [soc_bus_pkg::DataWidth-1:0]   dm_device_rdata_i,
  // Control register outputs
  output logic [63:0]                         exit_o,
  output logic [63:0]                         hw_cnt_en_o
);
  import soc_bus_pkg::*;

  bus_req_t sys_req;
  bus_rsp_t sys_rsp;
  bus_req_t l2_req;
  bus_rsp_t l2_rsp;
  bus_req_t ctrl_req;
  bus_rsp_t ctrl_rsp;

  sba_bridge_fsm i_sba_bridge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sba_req_i    (sba_req_i),
    .sba_we_i     (sba_we_i),
    .sba_addr_i   (sba_addr_i),
    .sba_be_i     (sba_be_i),
    .sba_wdata_i  (sba_wdata_i),
    .bus_rsp_i    (sys_rsp),
    .sba_gnt_o    (sba_gnt_o),
    .sba_r_valid_o(sba_r_valid_o),
    .sba_r_rdata_o(sba_r_rdata_o),
    .bus_req_o    (sys_req)
  );

  soc_bus_decoder i_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_req_i        (sys_req),
    .l2_rsp_i         (l2_rsp),
    .ctrl_rsp_i       (ctrl_rsp),
    .dm_device_rdata_i(dm_device_rdata_i),
    .bus_rsp_o        (sys_rsp),
    .l2_req_o         (l2_req),
    .ctrl_req_o       (ctrl_req),
    .dm_device_req_o  (dm_device_req_o),
    .dm_device_we_o   (dm_device_we_o),
    .dm_device_addr_o (dm_device_addr_o),
    .dm_device_be_o   (dm_device_be_o),
    .dm_device_wdata_o(dm_device_wdata_o)
  );

  l2_sram i_l2 (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .req_i (l2_req),
    .rsp_o (l2_rsp)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ctrl_req),
    .rsp_o      (ctrl_rsp),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

/* verif/sba_soc_checker.sv */
// Response checker for the SBA SoC testbench
// Compares read data and control outputs at each SBA response,
// the request forwarded to the debug window, the grant-to-response
// latency and the output levels after reset

`timescale 1ns/100ps

module sba_soc_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              gnt_i,
  input  logic                              r_valid_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] rdata_i,
  input  logic                              dm_req_i,
  input  logic                              dm_we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0] dm_addr_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0] dm_be_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] dm_wdata_i,
  input  logic [63:0]                       exit_i,
  input  logic [63:0]                       cnt_en_i,
  input  int                                test_id_i,
  input  logic                              exp_we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0] exp_addr_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0] exp_be_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] exp_wdata_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] exp_rdata_i,
  input  logic [63:0]                       exp_exit_i,
  input  logic [63:0]                       exp_cnt_en_i,
  output int                                test_count_o,
  output int                                error_count_o
);
  import soc_bus_pkg::*;

  // Grant in cycle N, response in cycle N+2
  localparam int ExpLatency = 2;

  bit busy;
  bit reset_checked;
  int latency;
  int errs_before;

  initial begin
    test_count_o  = 0;
    error_count_o = 0;
    busy          = 1'b0;
    reset_checked = 1'b0;
    latency       = 0;
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: test %0d %s is %h, expected %h",
               $time, test_id_i, what, got, exp);
      error_count_o++;
    end
  endtask

  task automatic report_test(input string label, input int errs_at_start);
    test_count_o++;
    if (error_count_o == errs_at_start) begin
      $display("%s: ok", label);
    end else begin
      $display("%s: failed with %0d errors", label, error_count_o - errs_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling at the falling edge, where outputs are settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      busy    = 1'b0;
      latency = 0;
    end else begin
      if (!reset_checked) begin
        errs_before = error_count_o;
        if (gnt_i || r_valid_i || dm_req_i || exit_i != '0 || cnt_en_i != '0) begin
          $display("ERROR at %0t: outputs not idle after reset", $time);
          error_count_o++;
        end
        report_test("reset levels", errs_before);
        reset_checked = 1'b1;
      end
      if (busy) latency++;
      // Debug window sees the access exactly as it was issued
      if (dm_req_i) begin
        check_value("dm_device_we_o", dm_we_i, exp_we_i);
        check_value("dm_device_addr_o", dm_addr_i, exp_addr_i);
        check_value("dm_device_be_o", dm_be_i, exp_be_i);
        check_value("dm_device_wdata_o", dm_wdata_i, exp_wdata_i);
      end
      if (r_valid_i) begin
        if (!busy) begin
          errs_before = error_count_o;
          $display("ERROR at %0t: test %0d response without a grant", $time, test_id_i);
          error_count_o++;
        end else if (latency != ExpLatency) begin
          $display("ERROR at %0t: test %0d latency %0d cycles, expected %0d",
                   $time, test_id_i, latency, ExpLatency);
          error_count_o++;
        end
        check_value("rdata", rdata_i, exp_rdata_i);
        check_value("exit_o", exit_i, exp_exit_i);
        check_value("hw_cnt_en_o", cnt_en_i, exp_cnt_en_i);
        report_test($sformatf("test %0d", test_id_i), errs_before);
        busy = 1'b0;
      end
      if (gnt_i) begin
        busy        = 1'b1;
        latency     = 0;
        errs_before = error_count_o;
      end
    end
  end

endmodule

/* verif/tb_sba_soc.sv */
// Testbench top for the SBA SoC: clock, reset, debug window stub
// and a table of SBA accesses with expected responses

`timescale 1ns/100ps

module tb_sba_soc;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int NumRows = 13;
  localparam int MaxWait = 20;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] exp_rdata;
    logic [63:0]          exp_exit;
    logic [63:0]          exp_cnt_en;
  } row_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 sba_req;
  logic                 sba_we;
  logic [AddrWidth-1:0] sba_addr;
  logic [StrbWidth-1:0] sba_be;
  logic [DataWidth-1:0] sba_wdata;
  logic                 sba_gnt;
  logic                 sba_r_valid;
  logic [DataWidth-1:0] sba_r_rdata;
  logic                 dm_req;
  logic                 dm_we;
  logic [AddrWidth-1:0] dm_addr;
  logic [StrbWidth-1:0] dm_be;
  logic [DataWidth-1:0] dm_wdata;
  logic [DataWidth-1:0] dm_rdata;
  logic [63:0]          exit_code;
  logic [63:0]          hw_cnt_en;

  row_t                 rows [NumRows];
  row_t                 cur;
  int                   n_rows;
  int                   test_id;
  int                   seed;
  int                   test_count;
  int                   error_count;
  bit                   timed_out;
  logic [63:0]          model_exit;
  logic [63:0]          model_cnt_en;
  logic [AddrWidth-1:0] stub_addr;

  always #4 clk = ~clk;

  sba_soc_top uut (
    .clk_i(clk), .rst_ni(rst_n),
    .sba_req_i(sba_req), .sba_we_i(sba_we), .sba_addr_i(sba_addr),
    .sba_be_i(sba_be), .sba_wdata_i(sba_wdata),
    .sba_gnt_o(sba_gnt), .sba_r_valid_o(sba_r_valid), .sba_r_rdata_o(sba_r_rdata),
    .dm_device_req_o(dm_req), .dm_device_we_o(dm_we), .dm_device_addr_o(dm_addr),
    .dm_device_be_o(dm_be), .dm_device_wdata_o(dm_wdata), .dm_device_rdata_i(dm_rdata),
    .exit_o(exit_code), .hw_cnt_en_o(hw_cnt_en)
  );

  sba_soc_checker i_checker (
    .clk_i(clk), .rst_ni(rst_n), .gnt_i(sba_gnt), .r_valid_i(sba_r_valid),
    .rdata_i(sba_r_rdata), .dm_req_i(dm_req), .dm_we_i(dm_we), .dm_addr_i(dm_addr),
    .dm_be_i(dm_be), .dm_wdata_i(dm_wdata), .exit_i(exit_code), .cnt_en_i(hw_cnt_en),
    .test_id_i(test_id), .exp_we_i(cur.we), .exp_addr_i(cur.addr), .exp_be_i(cur.be),
    .exp_wdata_i(cur.wdata), .exp_rdata_i(cur.exp_rdata), .exp_exit_i(cur.exp_exit),
    .exp_cnt_en_i(cur.exp_cnt_en), .test_count_o(test_count), .error_count_o(error_count)
  );

  // Debug window stub returns the inverted address of a read one cycle later
  always @(negedge clk) begin
    if (dm_req && !dm_we) begin
      stub_addr = dm_addr;
      @(posedge clk);
      #1;
      dm_rdata = ~stub_addr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Expected-value helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                              input logic [63:0] new_w,
                                              input logic [7:0]  be);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) mask[b*8 +: 8] = {8{be[b]}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] r;
    r[63:32] = $random(seed);
    r[31:0]  = $random(seed);
    return r;
  endfunction

  task automatic add_row(input logic we, input logic [63:0] addr, input logic [7:0] be,
                         input logic [63:0] wdata, input logic [63:0] exp_rdata);
    rows[n_rows].we         = we;
    rows[n_rows].addr       = addr;
    rows[n_rows].be         = be;
    rows[n_rows].wdata      = wdata;
    rows[n_rows].exp_rdata  = exp_rdata;
    rows[n_rows].exp_exit   = model_exit;
    rows[n_rows].exp_cnt_en = model_cnt_en;
    n_rows++;
  endtask

  task automatic build_table();
    logic [63:0] w_full;
    logic [63:0] w_part;
    logic [63:0] w_exit;
    logic [63:0] w_cnt;
    logic [63:0] w_junk;
    logic [63:0] l2_word;
    w_full  = rand64();
    w_part  = rand64();
    w_exit  = rand64();
    w_cnt   = rand64();
    w_junk  = rand64();
    l2_word = merge_bytes(w_full, w_part, 8'h5A);
    add_row(1'b1, DramBase + 64'h100, 8'hFF, w_full, '0);
    add_row(1'b0, DramBase + 64'h100, 8'hFF, '0, w_full);
    add_row(1'b1, DramBase + 64'h100, 8'h5A, w_part, '0);
    // 2 KiB higher hits the same L2 word
    add_row(1'b0, DramBase + 64'h900, 8'hFF, '0, l2_word);
    model_exit = w_exit;
    add_row(1'b1, CtrlBase + CtrlExitOffset, 8'hFF, w_exit, '0);
    model_cnt_en = w_cnt;
    add_row(1'b1, CtrlBase + CtrlCntEnOffset, 8'hFF, w_cnt, '0);
    add_row(1'b0, CtrlBase + CtrlExitOffset, 8'hFF, '0, w_exit);
    add_row(1'b0, CtrlBase + CtrlCntEnOffset, 8'hFF, '0, w_cnt);
    add_row(1'b0, DebugBase + 64'h40, 8'hFF, '0, ~(DebugBase + 64'h40));
    add_row(1'b1, DebugBase + 64'h40, 8'hFF, w_junk, '0);
    add_row(1'b0, 64'hC000_0000, 8'hFF, '0, '0);
    // Same L2 word index as the tested DRAM word, so a leak would show
    add_row(1'b1, 64'hC000_0100, 8'hFF, w_junk, '0);
    add_row(1'b0, DramBase + 64'h100, 8'hFF, '0, l2_word);
  endtask

  ////////////////////////////////////////////////////////////
  // One SBA access: request until grant, then wait for the response
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    int waited;
    @(posedge clk);
    #1;
    test_id   = idx;
    cur       = rows[idx];
    sba_req   = 1'b1;
    sba_we    = cur.we;
    sba_addr  = cur.addr;
    sba_be    = cur.be;
    sba_wdata = cur.wdata;
    waited    = 0;
    @(negedge clk);
    while (!sba_gnt && waited < MaxWait) begin
      waited++;
      @(negedge clk);
    end
    if (!sba_gnt) begin
      $display("Timeout: no grant seen for test %0d", idx);
      timed_out = 1'b1;
      sba_req   = 1'b0;
      return;
    end
    @(posedge clk);
    #1;
    sba_req = 1'b0;
    waited  = 0;
    @(negedge clk);
    while (!sba_r_valid && waited < MaxWait) begin
      waited++;
      @(negedge clk);
    end
    if (!sba_r_valid) begin
      $display("Timeout: no response seen for test %0d", idx);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    sba_req      = 1'b0;
    sba_we       = 1'b0;
    sba_addr     = '0;
    sba_be       = '0;
    sba_wdata    = '0;
    dm_rdata     = '0;
    test_id      = -1;
    cur          = '0;
    n_rows       = 0;
    timed_out    = 1'b0;
    model_exit   = '0;
    model_cnt_en = '0;
    seed         = 16068;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_rows && !timed_out; i++) begin
      run_row(i);
    end
    repeat (2) @(posedge clk);
    $display("Summary: %0d tests, %0d errors, timeout %0d", test_count, error_count, timed_out);
    if (timed_out || error_count != 0 || test_count != n_rows + 1) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

/* compile.f */
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
verilog/l2_sram.sv
verilog/ctrl_regs.sv
verilog/soc_bus_decoder.sv
sba/sba_bridge_fsm.sv
verilog/sba_soc_top.sv
verif/sba_soc_checker.sv
verif/tb_sba_soc.sv

/* Bender.yml */
package:
  name: sba_soc

sources:
  # Shared packages
  - files:
      - common/soc_bus_pkg.sv
      - common/soc_map_pkg.sv

  # Design
  - files:
      - verilog/l2_sram.sv
      - verilog/ctrl_regs.sv
      - verilog/soc_bus_decoder.sv
      - sba/sba_bridge_fsm.sv
      - verilog/sba_soc_top.sv

  # Testbench
  - target: test
    files:
      - verif/sba_soc_checker.sv
      - verif/tb_sba_soc.sv
